// File: src/wqe_sched_params.svh
`ifndef WQE_SCHED_PARAMS_SVH
`define WQE_SCHED_PARAMS_SVH

////////////////////////////////////////////////////////////
// queue pair population
////////////////////////////////////////////////////////////

`define MAX_QP          32  // multiple of 8, at least 16
`define QP_GRP_SIZE     8   // qps per search group

////////////////////////////////////////////////////////////
// derived widths
////////////////////////////////////////////////////////////

`define QP_PTR_WIDTH    5   // bits of a qp index
`define QP_OFF_WIDTH    3   // offset inside a group
`define QP_NUM_GRPS     4   // MAX_QP / QP_GRP_SIZE
`define QP_GRP_WIDTH    2   // bits of a group index

`endif

// File: src/wqe_sched_types_pkg.sv
`default_nettype none

`include "wqe_sched_params.svh"

package wqe_sched_types_pkg;

    ////////////////////////////////////////////////////////////
    // index types
    ////////////////////////////////////////////////////////////

    // full qp index, upper bits select the group
    typedef logic [`QP_PTR_WIDTH-1:0] qp_idx_t;

    typedef logic [`QP_GRP_WIDTH-1:0] qp_grp_t;    // group number
    typedef logic [`QP_OFF_WIDTH-1:0] qp_off_t;    // position inside a group

    ////////////////////////////////////////////////////////////
    // mask types
    ////////////////////////////////////////////////////////////

    // bit n set means qp n has work queued
    typedef logic [`MAX_QP-1:0] qp_mask_t;

    typedef logic [`QP_NUM_GRPS-1:0] grp_mask_t;   // one flag per group

endpackage

`default_nettype wire

// File: src/wqe_sched_ctrl_pkg.sv
`default_nettype none

`include "wqe_sched_params.svh"

package wqe_sched_ctrl_pkg;

    // grant controller states
    //   IDLE   : nothing active, wait for work
    //   SELECT : search request outstanding
    //   OFFER  : index presented on the grant handshake
    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,
        SELECT = 2'd1,
        OFFER  = 2'd2
    } grant_state_e;

endpackage

`default_nettype wire

// File: src/wqe_sched_if.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

////////////////////////////////////////////////////////////
// per-group activity tables
////////////////////////////////////////////////////////////

interface qp_scan_if
    import wqe_sched_types_pkg::*;
();

    qp_mask_t                       active_q;       // registered activity mask
    grp_mask_t                      grp_valid;      // any qp active in group
    qp_off_t [`QP_NUM_GRPS-1:0]     grp_first_off;  // lowest active offset per group
    logic                           any_active;

    modport producer
    (
        output active_q,
        output grp_valid,
        output grp_first_off,
        output any_active
    );

    modport consumer
    (
        input  active_q,
        input  grp_valid,
        input  grp_first_off,
        input  any_active
    );

endinterface

////////////////////////////////////////////////////////////
// search request and result
////////////////////////////////////////////////////////////

interface qp_select_if
    import wqe_sched_types_pkg::*;
();

    logic       req;        // one cycle pulse
    qp_idx_t    start_qp;   // search starts after this qp
    logic       done;       // one cycle after req
    qp_idx_t    next_qp;
    logic       found;

    modport requester
    (
        output req,
        output start_qp,
        input  done,
        input  next_qp,
        input  found
    );

    modport responder
    (
        input  req,
        input  start_qp,
        output done,
        output next_qp,
        output found
    );

endinterface

`default_nettype wire

// File: src/qp_group_scan.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

module qp_group_scan
    import wqe_sched_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire qp_mask_t   i_active,
    qp_scan_if.producer     scan
);

    localparam int NUM_GRPS = `QP_NUM_GRPS;
    localparam int GRP_SIZE = `QP_GRP_SIZE;

    // lowest set bit of one group, 0 when the group is empty
    function automatic qp_off_t lowest_off(input logic [GRP_SIZE-1:0] bits);
        qp_off_t off;
        off = '0;
        for (int j = GRP_SIZE - 1; j >= 0; j--)
        begin
            if (bits[j])
                off = qp_off_t'(j);     // later hits are lower, so they win
        end
        return off;
    endfunction

    ////////////////////////////////////////////////////////////
    // stage 1: sample the activity mask
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            scan.active_q <= '0;
        else
            scan.active_q <= i_active;
    end

    assign scan.any_active = |scan.active_q;

    ////////////////////////////////////////////////////////////
    // stage 2: group tables built from the sampled mask
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            scan.grp_valid <= '0;
        else
        begin
            for (int g = 0; g < NUM_GRPS; g++)
                scan.grp_valid[g] <= |scan.active_q[g*GRP_SIZE +: GRP_SIZE];
        end
    end

    // offsets only matter where grp_valid is set
    always_ff @(posedge clk)
    begin
        for (int g = 0; g < NUM_GRPS; g++)
            scan.grp_first_off[g] <= lowest_off(scan.active_q[g*GRP_SIZE +: GRP_SIZE]);
    end

endmodule

`default_nettype wire

// File: src/qp_rr_select.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

module qp_rr_select
    import wqe_sched_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    qp_scan_if.consumer     scan,
    qp_select_if.responder  sel
);

    localparam int NUM_GRPS = `QP_NUM_GRPS;
    localparam int GRP_SIZE = `QP_GRP_SIZE;

    qp_grp_t                cur_grp;        // group of the start qp
    qp_off_t                cur_off;
    logic [GRP_SIZE-1:0]    cur_bits;       // live activity of that group
    logic                   in_grp_hit;
    qp_off_t                in_grp_off;
    grp_mask_t              grp_rot;        // grp_valid rotated to start after cur_grp
    logic                   grp_hit;
    qp_grp_t                nxt_grp;
    qp_idx_t                nxt_qp_comb;

    // group number modulo the group count
    function automatic qp_grp_t grp_wrap(input int g);
        return qp_grp_t'(g % NUM_GRPS);
    endfunction

    assign cur_grp  = sel.start_qp[`QP_PTR_WIDTH-1:`QP_OFF_WIDTH];
    assign cur_off  = sel.start_qp[`QP_OFF_WIDTH-1:0];
    assign cur_bits = scan.active_q[cur_grp*GRP_SIZE +: GRP_SIZE];

    ////////////////////////////////////////////////////////////
    // level 1: further on inside the current group
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        in_grp_hit = 1'b0;
        in_grp_off = '0;
        for (int j = GRP_SIZE - 1; j > 0; j--)
        begin
            if (j > cur_off && cur_bits[j])
            begin
                in_grp_hit = 1'b1;
                in_grp_off = qp_off_t'(j);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // level 2: next valid group, current group comes last
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < NUM_GRPS; k++)
            grp_rot[k] = scan.grp_valid[grp_wrap(int'(cur_grp) + 1 + k)];
    end

    always_comb
    begin
        grp_hit = 1'b0;
        nxt_grp = cur_grp;
        for (int k = NUM_GRPS - 1; k >= 0; k--)
        begin
            if (grp_rot[k])
            begin
                grp_hit = 1'b1;
                nxt_grp = grp_wrap(int'(cur_grp) + 1 + k);  // nearest group wins
            end
        end
    end

    always_comb
    begin
        if (in_grp_hit)
            nxt_qp_comb = {cur_grp, in_grp_off};
        else
            nxt_qp_comb = {nxt_grp, scan.grp_first_off[nxt_grp]};
    end

    // result register, done answers req one cycle later
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sel.done  <= 1'b0;
            sel.found <= 1'b0;
        end
        else
        begin
            sel.done <= sel.req;
            if (sel.req)
                sel.found <= in_grp_hit | grp_hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sel.req)
            sel.next_qp <= nxt_qp_comb;
    end

endmodule

`default_nettype wire

// File: src/grant_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

module grant_ctrl
    import wqe_sched_types_pkg::*;
    import wqe_sched_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       i_grant_ready,
    input  wire logic       i_enable,
    output logic            o_grant_valid,
    output qp_idx_t         o_qp_idx,
    output qp_mask_t        o_qp_idx_one_hot,
    qp_scan_if.consumer     scan,
    qp_select_if.requester  sel
);

    grant_state_e   state;
    grant_state_e   state_nxt;
    qp_idx_t        offer_qp;       // index on the handshake
    qp_idx_t        last_qp;        // last accepted index
    logic           revoked;        // next search restarts from offer_qp
    logic           offer_live;
    logic           accept;
    logic           revoke;

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    assign offer_live    = scan.active_q[offer_qp];
    assign o_grant_valid = (state == OFFER) && offer_live;     // drops at once on revoke
    assign accept        = o_grant_valid && i_grant_ready;
    assign revoke        = (state == OFFER) && !offer_live;
    assign o_qp_idx      = offer_qp;

    // done only ever comes in the second SELECT cycle
    assign sel.req      = (state == SELECT) && !sel.done;
    assign sel.start_qp = revoked ? offer_qp : last_qp;

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
                if (scan.any_active)
                    state_nxt = SELECT;
            SELECT:
                if (sel.done)
                    state_nxt = (sel.found && scan.any_active) ? OFFER : IDLE;
            OFFER:
                if (accept || revoke)
                    state_nxt = SELECT;
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            last_qp  <= qp_idx_t'(`MAX_QP - 1);    // first grant is the lowest active qp
            offer_qp <= '0;
            revoked  <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (accept)
                last_qp <= offer_qp;
            if (state == SELECT && state_nxt == OFFER)
                offer_qp <= sel.next_qp;
            if (revoke)
                revoked <= 1'b1;
            else if (accept || state_nxt == IDLE)
                revoked <= 1'b0;
        end
    end

    // one-hot copy of the index, follows o_qp_idx regardless of valid
    always_comb
    begin
        o_qp_idx_one_hot = '0;
        if (i_enable)
            o_qp_idx_one_hot[o_qp_idx] = 1'b1;
    end

endmodule

`default_nettype wire

// File: src/wqe_sched_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

module wqe_sched_top
    import wqe_sched_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire qp_mask_t   i_active,       // one bit per qp with queued work
    input  wire logic       i_grant_ready,
    input  wire logic       i_enable,       // gates the one-hot output
    output logic            o_grant_valid,
    output qp_idx_t         o_qp_idx,
    output qp_mask_t        o_qp_idx_one_hot
);

    ////////////////////////////////////////////////////////////
    // internal buses
    ////////////////////////////////////////////////////////////

    qp_scan_if   scan_bus ();
    qp_select_if sel_bus ();

    ////////////////////////////////////////////////////////////
    // mask register and group tables
    ////////////////////////////////////////////////////////////

    qp_group_scan u_group_scan
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_active   (i_active),
        .scan       (scan_bus.producer)
    );

    // two-level round-robin search
    qp_rr_select u_rr_select
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan       (scan_bus.consumer),
        .sel        (sel_bus.responder)
    );

    ////////////////////////////////////////////////////////////
    // grant handshake
    ////////////////////////////////////////////////////////////

    grant_ctrl u_grant_ctrl
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_grant_ready      (i_grant_ready),
        .i_enable           (i_enable),
        .o_grant_valid      (o_grant_valid),
        .o_qp_idx           (o_qp_idx),
        .o_qp_idx_one_hot   (o_qp_idx_one_hot),
        .scan               (scan_bus.consumer),
        .sel                (sel_bus.requester)
    );

endmodule

`default_nettype wire

// File: dv/wqe_sched_properties.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

module wqe_sched_properties
    import wqe_sched_types_pkg::*;
    import wqe_sched_ctrl_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           i_grant_ready,
    input  wire logic           i_enable,
    input  wire logic           o_grant_valid,
    input  wire qp_idx_t        o_qp_idx,
    input  wire qp_mask_t       o_qp_idx_one_hot,
    input  wire grant_state_e   state           // controller state inside grant_ctrl
);

    int fail_count = 0;     // read by the testbench

    ////////////////////////////////////////////////////////////
    // grant handshake
    ////////////////////////////////////////////////////////////

    // a waiting offer keeps its index until it transfers or is withdrawn
    hold_idx: assert property (@(posedge clk) disable iff (!rst_n)
        o_grant_valid && !i_grant_ready |=> !o_grant_valid || o_qp_idx == $past(o_qp_idx))
    else
    begin
        fail_count++;
        $error("offered qp index changed while waiting for ready");
    end

    // an accepted grant is followed by a two cycle search
    accept_search: assert property (@(posedge clk) disable iff (!rst_n)
        o_grant_valid && i_grant_ready |=> state == SELECT ##1 state == SELECT)
    else
    begin
        fail_count++;
        $error("controller did not search for two cycles after an accepted grant");
    end

    ////////////////////////////////////////////////////////////
    // one-hot copy of the index
    ////////////////////////////////////////////////////////////

    one_hot_on: assert property (@(posedge clk)
        i_enable |-> o_qp_idx_one_hot == (qp_mask_t'(1) << o_qp_idx))
    else
    begin
        fail_count++;
        $error("one-hot output does not decode the qp index");
    end

    one_hot_off: assert property (@(posedge clk)
        !i_enable |-> o_qp_idx_one_hot == '0)
    else
    begin
        fail_count++;
        $error("one-hot output not zero while disabled");
    end

endmodule

bind wqe_sched_top wqe_sched_properties u_props
(
    .clk                (clk),
    .rst_n              (rst_n),
    .i_grant_ready      (i_grant_ready),
    .i_enable           (i_enable),
    .o_grant_valid      (o_grant_valid),
    .o_qp_idx           (o_qp_idx),
    .o_qp_idx_one_hot   (o_qp_idx_one_hot),
    .state              (u_grant_ctrl.state)
);

`default_nettype wire

// File: dv/wqe_sched_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "wqe_sched_params.svh"

module wqe_sched_tb
    import wqe_sched_types_pkg::*;
();

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 6;    // zero mask long enough for the FSM to reach IDLE
    localparam int OFFER_LIMIT  = 8;
    localparam int NUM_DIRECTED = 4;
    localparam int DIR_GRANTS   = 6;
    localparam int NUM_RANDOM   = 12;
    localparam int RAND_GRANTS  = 5;
    localparam int TOTAL_GRANTS = NUM_DIRECTED * DIR_GRANTS + NUM_RANDOM * RAND_GRANTS + 1;
    localparam int NUM_MASKS    = NUM_DIRECTED + NUM_RANDOM + 1;
    localparam int WATCHDOG_NS  = (TOTAL_GRANTS * 12 + NUM_MASKS * 16 + 100) * 2 * CLK_HALF;

    localparam qp_mask_t DIR_MASK [NUM_DIRECTED] = '{
        32'h0000_0100,      // single qp, wraps onto itself
        32'h0000_9600,      // one group only
        32'h8001_0204,      // sparse across all groups
        32'h8000_0001       // both ends of the index range
    };
    localparam qp_mask_t REVOKE_MASK = 32'h0102_0408;

    logic           clk;
    logic           rst_n;
    qp_mask_t       i_active;
    logic           i_grant_ready;
    logic           i_enable;
    logic           o_grant_valid;
    qp_idx_t        o_qp_idx;
    qp_mask_t       o_qp_idx_one_hot;

    logic [31:0]    lcg_state;
    qp_mask_t       model_mask;         // mask currently held on i_active
    qp_idx_t        model_last;         // last accepted index

    wqe_sched_top i_dut
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_active           (i_active),
        .i_grant_ready      (i_grant_ready),
        .i_enable           (i_enable),
        .o_grant_valid      (o_grant_valid),
        .o_qp_idx           (o_qp_idx),
        .o_qp_idx_one_hot   (o_qp_idx_one_hot)
    );

    always #CLK_HALF clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random numbers and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[31];
    endfunction

    // upper halves only, the low lcg bits repeat quickly
    function automatic qp_mask_t rand_mask();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        qp_mask_t    m;
        a = next_rand();
        b = next_rand();
        c = next_rand();
        d = next_rand();
        m = {a[31:16], b[31:16]} & {c[31:16], d[31:16]};
        if (m == '0)
            m = qp_mask_t'(1) << a[31:27];
        return m;
    endfunction

    // first set bit strictly after last, wrapping
    function automatic qp_idx_t expected_next(input qp_mask_t mask, input qp_idx_t last);
        qp_idx_t idx;
        qp_idx_t pick;
        pick = last;
        for (int k = `MAX_QP; k >= 1; k--)
        begin
            idx = qp_idx_t'((int'(last) + k) % `MAX_QP);
            if (mask[idx])
                pick = idx;     // nearest one is seen last
        end
        return pick;
    endfunction

    ////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test_name, input int expected, input int actual);
        abort_run($sformatf("** Error [%s] expected %0d, actual %0d", test_name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // pass through an all-zero mask so the controller restarts from last_qp
    task automatic apply_mask(input qp_mask_t mask);
        @(negedge clk);
        i_grant_ready = 1'b0;
        i_active      = '0;
        repeat (DRAIN_CYCLES) @(negedge clk);
        i_active   = mask;
        model_mask = mask;
    endtask

    task automatic wait_offer(input string test_name);
        int cycles;
        cycles = 0;
        while (!o_grant_valid)
        begin
            @(negedge clk);
            cycles++;
            assert (cycles <= OFFER_LIMIT)
            else
                abort_run($sformatf("%s: no grant offered within %0d cycles",
                                    test_name, OFFER_LIMIT));
        end
    endtask

    task automatic take_grant(input string test_name, input logic random_ready);
        qp_idx_t exp_qp;
        logic    accepted;
        exp_qp   = expected_next(model_mask, model_last);
        accepted = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            i_grant_ready = random_ready ? rand_bit() : 1'b1;
            if (random_ready)
                i_enable = rand_bit();
            if (o_grant_valid && i_grant_ready)     // valid only depends on registers
            begin
                accepted = 1'b1;
                assert (o_qp_idx == exp_qp)
                else
                    report_mismatch(test_name, exp_qp, o_qp_idx);
            end
        end
        @(posedge clk);     // transfer edge
        model_last = exp_qp;
    endtask

    initial
    begin
        #WATCHDOG_NS;
        abort_run("watchdog expired before all tests finished");
    end

    always @(negedge clk)
    begin
        if (i_dut.u_props.fail_count != 0)
            abort_run("a handshake or one-hot assertion on the DUT failed");
    end

    initial
    begin
        qp_idx_t victim;
        clk           = 1'b0;
        rst_n         = 1'b0;
        i_active      = '0;
        i_grant_ready = 1'b0;
        i_enable      = 1'b0;
        lcg_state     = 32'd10;
        model_mask    = '0;
        model_last    = qp_idx_t'(`MAX_QP - 1);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n    = 1'b1;
        i_enable = 1'b1;

        // idle with no active qp
        repeat (10)
        begin
            assert (!o_grant_valid)
            else
                report_mismatch("idle", 0, o_grant_valid);
            @(negedge clk);
        end

        for (int m = 0; m < NUM_DIRECTED; m++)
        begin
            apply_mask(DIR_MASK[m]);
            repeat (DIR_GRANTS)
                take_grant($sformatf("directed_%0d", m), 1'b0);
        end

        // revocation, offered qp goes inactive while ready is low
        apply_mask(REVOKE_MASK);
        wait_offer("revoke_first_offer");
        victim     = o_qp_idx;
        assert (victim == expected_next(model_mask, model_last))
        else
            report_mismatch("revoke_first_offer", expected_next(model_mask, model_last), victim);
        // a qp just behind the victim wakes up, so the search must start at the victim
        i_active   = (REVOKE_MASK & ~(qp_mask_t'(1) << victim))
                   | (qp_mask_t'(1) << qp_idx_t'(victim - 1));
        model_mask = i_active;
        @(negedge clk);
        wait_offer("revoke_reoffer");
        assert (o_qp_idx == expected_next(model_mask, victim))
        else
            report_mismatch("revoke_reoffer", expected_next(model_mask, victim), o_qp_idx);
        repeat (4)
        begin
            @(negedge clk);
            assert (!o_grant_valid || model_mask[o_qp_idx])
            else
                report_mismatch("revoke_stale", 1, model_mask[o_qp_idx]);
        end

        for (int m = 0; m < NUM_RANDOM; m++)
        begin
            apply_mask(rand_mask());
            repeat (RAND_GRANTS)
                take_grant($sformatf("random_%0d", m), 1'b1);
        end

        @(negedge clk);
        if (i_dut.u_props.fail_count != 0)
            abort_run("a bound assertion on the DUT failed");
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/wqe_sched_types_pkg.sv
src/wqe_sched_ctrl_pkg.sv
src/wqe_sched_if.sv
src/qp_group_scan.sv
src/qp_rr_select.sv
src/grant_ctrl.sv
src/wqe_sched_top.sv
dv/wqe_sched_properties.sv
dv/wqe_sched_tb.sv
